//--- sources.f
logic/desc_pkg.sv
logic/desc_if.sv
logic/buf_admit.sv
logic/flow_parser.sv
logic/desc_rr_arb.sv
logic/desc_extract_top.sv
bench/desc_extract_chk.sv
bench/tb_desc_extract.sv

//--- bench/tb_desc_extract.sv
// directed testbench that drives frames on the extractor ports and checks every output
`timescale 1ns/1ns

module tb_desc_extract;

    localparam int np          = desc_pkg::num_ports;
    localparam int frame_cyc   = 30;                        // one frame plus settling
    localparam int wd_cycles   = 10 + 6 * 100 + 40 * frame_cyc;

    logic                 clk_sys;
    logic                 reset_n;
    logic                 i_desc_ready;
    desc_pkg::pkt_byte_t  i_data [np];
    desc_pkg::pkt_byte_t  o_data [np];
    logic [np-1:0]        i_data_wr;
    logic [np-1:0]        o_data_wr;
    logic [np-1:0]        o_discard;
    desc_pkg::bufcnt_t    i_free_cnt;
    desc_pkg::bufcnt_t    i_rc_thr;
    desc_pkg::bufcnt_t    i_be_thr;
    logic                 o_desc_valid;
    desc_pkg::port_id_t   o_desc_port;
    desc_pkg::flow_type_t o_desc_flow_type;
    desc_pkg::flow_id_t   o_desc_flow_id;

    int unsigned    cyc = 0;
    logic [31:0]    lfsr = 32'd74634;
    logic [44:0]    in_q [$];                               // {cycle, port, word}
    logic [44:0]    out_q [$];
    logic [20:0]    desc_q [$];                             // {port, type, id}
    int             disc_cnt [np];
    int             err_cnt = 0;
    int             chk_cnt = 0;
    int             test_no = 0;

    desc_extract_top desc_extract_top_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // capture inputs, outputs, discards and transferred descriptors
    always @(posedge clk_sys) begin
        cyc <= cyc + 1;
        if (reset_n) begin
            for (int p = 0; p < np; p++) begin
                if (i_data_wr[p]) in_q.push_back({cyc, 4'(p), i_data[p]});
                if (o_data_wr[p]) out_q.push_back({cyc, 4'(p), o_data[p]});
                if (o_discard[p]) disc_cnt[p]++;
            end
            if (o_desc_valid && i_desc_ready)
                desc_q.push_back({o_desc_port, o_desc_flow_type, o_desc_flow_id});
        end
    end

    initial begin
        #(wd_cycles * 4);
        $display("timeout, the DUT stopped producing results");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] step_rand(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic desc_pkg::pkt_byte_t frame_word(desc_pkg::flow_type_t t,
                                                       desc_pkg::flow_id_t id, int k, int len);
        if (k == 0) return {1'b1, t, id[13:9]};
        if (k == 1) return {1'b0, id[8:1]};
        if (k == 2) return {1'b0, id[0], 7'h2a};
        return {k == len - 1, 8'(k * 37 + id[7:0])};        // tail has bit 8 set
    endfunction

    task automatic check_byte(desc_pkg::pkt_byte_t got, desc_pkg::pkt_byte_t exp, string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_port(desc_pkg::port_id_t got, desc_pkg::port_id_t exp, string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flow_type(desc_pkg::flow_type_t got, desc_pkg::flow_type_t exp,
                                   string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flow_id(desc_pkg::flow_id_t got, desc_pkg::flow_id_t exp, string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(logic [31:0] got, logic [31:0] exp, string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic send_frame(int p, desc_pkg::flow_type_t t, desc_pkg::flow_id_t id, int len);
        for (int k = 0; k < len; k++) begin
            @(posedge clk_sys);
            i_data[p]    <= frame_word(t, id, k, len);
            i_data_wr[p] <= 1'b1;
        end
        @(posedge clk_sys);
        i_data_wr[p] <= 1'b0;
    endtask

    task automatic wait_desc(int n);
        int waited;
        waited = 0;
        while (desc_q.size() < n && waited < 200) begin
            @(posedge clk_sys);
            waited++;
        end
        if (desc_q.size() < n) begin
            err_cnt++;
            $display("%0t ns: only %0d of %0d descriptors arrived", $time, desc_q.size(), n);
        end
    endtask

    task automatic set_count(desc_pkg::bufcnt_t cnt);
        @(posedge clk_sys);
        i_free_cnt <= cnt;
        repeat (3) @(posedge clk_sys);                      // admit flags are registered
        in_q.delete();
        out_q.delete();
        desc_q.delete();
        for (int p = 0; p < np; p++) disc_cnt[p] = 0;
    endtask

    task automatic report(string name, int err_before);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_before);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset();
        int e;
        e = err_cnt;
        check_count(o_data_wr, 0, "o_data_wr after reset");
        check_count(o_discard, 0, "o_discard after reset");
        check_count(o_desc_valid, 0, "o_desc_valid after reset");
        report("reset", e);
    endtask

    task automatic test_rc_frame();
        int e;
        e = err_cnt;
        set_count(9'd100);
        send_frame(0, desc_pkg::flow_type_rc, 14'h2d5b, 6);
        wait_desc(1);
        repeat (4) @(posedge clk_sys);
        check_count(out_q.size(), 6, "forwarded words");
        for (int k = 0; k < 6 && k < out_q.size() && k < in_q.size(); k++) begin
            check_byte(out_q[k][8:0], frame_word(3, 14'h2d5b, k, 6), "forwarded word");
            check_count(out_q[k][44:13], in_q[k][44:13] + 1, "forward latency cycle");
            check_port(out_q[k][12:9], 0, "forward port");
        end
        check_count(desc_q.size(), 1, "descriptor count");
        if (desc_q.size() > 0) begin
            check_port(desc_q[0][20:17], 0, "descriptor port");
            check_flow_type(desc_q[0][16:14], 3, "descriptor type");
            check_flow_id(desc_q[0][13:0], 14'h2d5b, "descriptor id");
        end
        report("rc frame", e);
    endtask

    task automatic try_admit(desc_pkg::bufcnt_t cnt, desc_pkg::flow_type_t t, bit admit);
        set_count(cnt);
        send_frame(1, t, 14'h1234, 5);
        repeat (10) @(posedge clk_sys);
        check_count(disc_cnt[1], admit ? 0 : 1, "discard pulses");
        check_count(out_q.size(), admit ? 5 : 0, "forwarded words");
        check_count(desc_q.size(), admit ? 1 : 0, "descriptors");
    endtask

    task automatic test_admission();
        int e;
        e = err_cnt;
        try_admit(9'd20, desc_pkg::flow_type_rc, 0);        // at rc threshold
        try_admit(9'd40, desc_pkg::flow_type_be, 0);        // above rc and at be
        try_admit(9'd1, 3'd2, 1);
        try_admit(9'd0, 3'd2, 0);
        report("admission", e);
    endtask

    task automatic test_all_ports();
        int e;
        int port;
        int seen [np];
        desc_pkg::flow_id_t ids [np];
        e = err_cnt;
        ids = '{14'h0101, 14'h1202, 14'h2303, 14'h3404};
        set_count(9'd100);
        i_desc_ready <= 1'b0;
        fork
            send_frame(0, 3'd1, ids[0], 5);
            send_frame(1, 3'd2, ids[1], 5);
            send_frame(2, 3'd3, ids[2], 5);
            send_frame(3, 3'd4, ids[3], 5);
        join
        repeat (14) @(posedge clk_sys);
        i_desc_ready <= 1'b1;
        wait_desc(4);
        repeat (6) @(posedge clk_sys);
        check_count(desc_q.size(), 4, "descriptor count");
        foreach (seen[p]) seen[p] = 0;
        foreach (desc_q[i]) begin
            port = int'(desc_q[i][20:17]);
            if (port < np) begin
                seen[port]++;
                check_flow_id(desc_q[i][13:0], ids[port], "per port flow id");
            end else begin
                err_cnt++;
                $display("%0t ns: descriptor names port %0d, which does not exist",
                         $time, port);
            end
        end
        foreach (seen[p]) check_count(seen[p], 1, "descriptors per port");
        report("all ports", e);
    endtask

    task automatic test_pending();
        int e;
        e = err_cnt;
        set_count(9'd100);
        i_desc_ready <= 1'b0;
        send_frame(0, 3'd1, 14'h0aaa, 5);                   // fills the output register
        send_frame(2, 3'd2, 14'h0bbb, 5);
        send_frame(2, 3'd2, 14'h0ccc, 5);
        repeat (8) @(posedge clk_sys);
        check_count(disc_cnt[2], 1, "second frame discarded");
        i_desc_ready <= 1'b1;
        wait_desc(2);
        repeat (6) @(posedge clk_sys);
        check_count(desc_q.size(), 2, "descriptor count");
        if (desc_q.size() == 2) begin
            check_port(desc_q[1][20:17], 2, "pending lane port");
            check_flow_id(desc_q[1][13:0], 14'h0bbb, "pending lane id");
        end
        report("pending", e);
    endtask

    task automatic test_random();
        int e;
        logic [20:0] exp_q [$];
        desc_pkg::flow_type_t t;
        desc_pkg::flow_id_t id;
        desc_pkg::bufcnt_t cnt;
        bit admit;
        int p;
        int hit;
        e = err_cnt;
        for (int f = 0; f < 20; f++) begin
            cnt = 9'(step_rand(6));
            t   = 3'(step_rand(3));
            id  = 14'(step_rand(14));
            p   = int'(step_rand(2));
            admit = (t == desc_pkg::flow_type_rc) ? cnt > 20 :
                    (t == desc_pkg::flow_type_be) ? (cnt > 20 && cnt > 40) : cnt != 0;
            set_count(cnt);
            send_frame(p, t, id, 4 + int'(step_rand(2)));
            if (admit) wait_desc(1);
            repeat (6) @(posedge clk_sys);
            check_count(disc_cnt[p], admit ? 0 : 1, "random frame discard");
            if (admit) exp_q.push_back({4'(p), t, id});
            foreach (desc_q[i]) begin
                hit = -1;
                foreach (exp_q[j]) begin
                    if (hit < 0 && exp_q[j][20:17] == desc_q[i][20:17] &&
                        exp_q[j][13:0] == desc_q[i][13:0]) begin
                        hit = j;
                    end
                end
                if (hit < 0) begin
                    err_cnt++;
                    $display("%0t ns: unexpected descriptor %h", $time, desc_q[i]);
                end else begin
                    check_flow_type(desc_q[i][16:14], exp_q[hit][16:14], "random type");
                    exp_q.delete(hit);
                end
            end
        end
        check_count(exp_q.size(), 0, "descriptors never delivered");
        report("random", e);
    endtask

    initial begin
        reset_n      = 1'b1;
        i_data_wr    = '0;
        i_desc_ready = 1'b1;
        i_free_cnt   = '0;
        i_rc_thr     = 9'd20;
        i_be_thr     = 9'd40;
        foreach (i_data[p]) i_data[p] = '0;
        foreach (disc_cnt[p]) disc_cnt[p] = 0;
        #1 reset_n = 1'b0;
        repeat (10) @(posedge clk_sys);
        reset_n <= 1'b1;
        @(posedge clk_sys);
        test_reset();
        test_rc_frame();
        test_admission();
        test_all_ports();
        test_pending();
        test_random();
        $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- bench/desc_extract_chk.sv
// assertions on the top level handshake and pulses, bound into the extractor top level
`timescale 1ns/1ns

module desc_extract_chk (
    input logic                                clk_sys,
    input logic                                reset_n,
    input logic                                i_desc_ready,
    input logic                                o_desc_valid,
    input desc_pkg::port_id_t                  o_desc_port,
    input desc_pkg::flow_type_t                o_desc_flow_type,
    input desc_pkg::flow_id_t                  o_desc_flow_id,
    input logic [desc_pkg::num_ports-1:0]      o_discard,
    input logic [desc_pkg::num_ports-1:0]      o_data_wr
);

    // held descriptor stays put until taken
    a_valid_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
        o_desc_valid && !i_desc_ready |=> o_desc_valid && $stable(o_desc_port) &&
        $stable(o_desc_flow_type) && $stable(o_desc_flow_id))
        else $error("descriptor dropped or changed before ready");

    for (genvar g = 0; g < desc_pkg::num_ports; g++) begin : g_disc
        a_disc_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
            o_discard[g] |=> !o_discard[g])
            else $error("discard longer than one cycle");
    end

    a_reset_quiet: assert property (@(posedge clk_sys)
        !reset_n |-> !o_desc_valid && o_discard == '0 && o_data_wr == '0)
        else $error("output active in reset");

endmodule

bind desc_extract_top desc_extract_chk desc_extract_chk_i (.*);

//--- logic/desc_extract_top.sv
// top level of the four-port descriptor extractor: admission, port lanes and descriptor merger
`timescale 1ns/1ns

module desc_extract_top (
    input  logic                           clk_sys,
    input  logic                           reset_n,
    input  desc_pkg::pkt_byte_t            i_data [desc_pkg::num_ports],
    input  logic [desc_pkg::num_ports-1:0] i_data_wr,
    input  desc_pkg::bufcnt_t              i_free_cnt,
    input  desc_pkg::bufcnt_t              i_rc_thr,
    input  desc_pkg::bufcnt_t              i_be_thr,
    input  logic                           i_desc_ready,
    output desc_pkg::pkt_byte_t            o_data [desc_pkg::num_ports],
    output logic [desc_pkg::num_ports-1:0] o_data_wr,
    output logic [desc_pkg::num_ports-1:0] o_discard,
    output logic                           o_desc_valid,
    output desc_pkg::port_id_t             o_desc_port,
    output desc_pkg::flow_type_t           o_desc_flow_type,
    output desc_pkg::flow_id_t             o_desc_flow_id
);

    logic admit_rc;
    logic admit_be;
    logic admit_other;

    desc_if lane_if [desc_pkg::num_ports] ();

    //////////////////////////////
    // admission, one for all lanes
    //////////////////////////////

    buf_admit buf_admit_i (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .i_free_cnt    (i_free_cnt),
        .i_rc_thr      (i_rc_thr),
        .i_be_thr      (i_be_thr),
        .o_admit_rc    (admit_rc),
        .o_admit_be    (admit_be),
        .o_admit_other (admit_other)
    );

    for (genvar g = 0; g < desc_pkg::num_ports; g++) begin : g_port
        flow_parser #(
            .lane_id (desc_pkg::port_id_t'(g))
        ) flow_parser_i (
            .clk_sys       (clk_sys),
            .reset_n       (reset_n),
            .i_data        (i_data[g]),
            .i_data_wr     (i_data_wr[g]),
            .i_admit_rc    (admit_rc),
            .i_admit_be    (admit_be),
            .i_admit_other (admit_other),
            .o_data        (o_data[g]),
            .o_data_wr     (o_data_wr[g]),
            .o_discard     (o_discard[g]),
            .d             (lane_if[g])
        );
    end

    desc_rr_arb desc_rr_arb_i (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .i_ready     (i_desc_ready),
        .lanes       (lane_if),
        .o_valid     (o_desc_valid),
        .o_port      (o_desc_port),
        .o_flow_type (o_desc_flow_type),
        .o_flow_id   (o_desc_flow_id)
    );

endmodule

//--- logic/desc_rr_arb.sv
// merges the lane descriptors round-robin into one registered valid/ready output
`timescale 1ns/1ns

module desc_rr_arb (
    input  logic                 clk_sys,
    input  logic                 reset_n,
    input  logic                 i_ready,
    desc_if.arb                  lanes [desc_pkg::num_ports],
    output logic                 o_valid,
    output desc_pkg::port_id_t   o_port,
    output desc_pkg::flow_type_t o_flow_type,
    output desc_pkg::flow_id_t   o_flow_id
);

    logic [desc_pkg::num_ports-1:0]         lane_valid;
    logic [desc_pkg::num_ports-1:0]         grant;
    desc_pkg::port_id_t                     lane_port [desc_pkg::num_ports];
    desc_pkg::flow_type_t                   lane_type [desc_pkg::num_ports];
    desc_pkg::flow_id_t                     lane_id   [desc_pkg::num_ports];
    logic [$clog2(desc_pkg::num_ports)-1:0] last_q;
    logic [$clog2(desc_pkg::num_ports)-1:0] pick;
    logic                                   found;
    logic                                   load_en;

    for (genvar g = 0; g < desc_pkg::num_ports; g++) begin : g_lane
        assign lane_valid[g]  = lanes[g].valid;
        assign lane_port[g]   = lanes[g].port;
        assign lane_type[g]   = lanes[g].flow_type;
        assign lane_id[g]     = lanes[g].flow_id;
        assign lanes[g].ready = grant[g];
    end

    assign load_en = !o_valid || i_ready;                   // empty or draining

    // first valid lane after the last winner
    always_comb begin : pick_lane
        int idx;
        pick  = last_q;
        found = 1'b0;
        grant = '0;
        for (int i = 1; i <= desc_pkg::num_ports; i++) begin
            idx = (int'(last_q) + i) % desc_pkg::num_ports;
            if (!found && lane_valid[idx]) begin
                found = 1'b1;
                pick  = idx[$clog2(desc_pkg::num_ports)-1:0];
            end
        end
        if (found && load_en) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
            last_q  <= '0;
        end else if (found && load_en) begin
            o_valid <= 1'b1;
            last_q  <= pick;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (found && load_en) begin
            o_port      <= lane_port[pick];
            o_flow_type <= lane_type[pick];
            o_flow_id   <= lane_id[pick];
        end
    end

endmodule

//--- logic/flow_parser.sv
// one ingress lane: admits or drops a frame on its head, forwards it and builds its descriptor
`timescale 1ns/1ns

module flow_parser #(
    parameter desc_pkg::port_id_t lane_id = 4'd0
) (
    input  logic                clk_sys,
    input  logic                reset_n,
    input  desc_pkg::pkt_byte_t i_data,
    input  logic                i_data_wr,
    input  logic                i_admit_rc,
    input  logic                i_admit_be,
    input  logic                i_admit_other,
    output desc_pkg::pkt_byte_t o_data,
    output logic                o_data_wr,
    output logic                o_discard,
    desc_if.lane                d
);

    desc_pkg::lane_state_t state;
    desc_pkg::flow_type_t  head_type;
    desc_pkg::flow_type_t  type_q;
    desc_pkg::flow_id_t    id_q;
    logic                  head_in;
    logic                  class_ok;
    logic                  admit_head;
    logic                  refuse_head;

    //////////////////////////////
    // head decision
    //////////////////////////////

    assign head_in   = i_data_wr && i_data[8];
    assign head_type = i_data[7:5];

    always_comb begin
        case (head_type)
            desc_pkg::flow_type_rc: class_ok = i_admit_rc;
            desc_pkg::flow_type_be: class_ok = i_admit_be;
            default:                class_ok = i_admit_other;
        endcase
    end

    // a lane holding an unsent descriptor takes no new frame
    assign admit_head  = (state == desc_pkg::lane_idle) && head_in && class_ok && !d.valid;
    assign refuse_head = (state == desc_pkg::lane_idle) && head_in && !(class_ok && !d.valid);

    //////////////////////////////
    // lane FSM
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state     <= desc_pkg::lane_idle;
            o_data_wr <= 1'b0;
            o_discard <= 1'b0;
            d.valid   <= 1'b0;
        end else begin
            o_discard <= refuse_head;                       // one cycle only
            if (state == desc_pkg::lane_id_lo && i_data_wr) begin
                d.valid <= 1'b1;                            // word 3 completes the id
            end else if (d.ready) begin
                d.valid <= 1'b0;
            end
            case (state)
                desc_pkg::lane_idle: begin
                    o_data_wr <= admit_head;
                    if (admit_head) begin
                        state <= desc_pkg::lane_id_hi;
                    end else if (refuse_head) begin
                        state <= desc_pkg::lane_drop;
                    end
                end
                desc_pkg::lane_id_hi: begin
                    o_data_wr <= i_data_wr;
                    if (i_data_wr && !i_data[8]) begin
                        state <= desc_pkg::lane_id_lo;
                    end else begin
                        state <= desc_pkg::lane_idle;       // short frame, no descriptor
                    end
                end
                desc_pkg::lane_id_lo: begin
                    o_data_wr <= i_data_wr;
                    if (i_data_wr && !i_data[8]) begin
                        state <= desc_pkg::lane_fwd;
                    end else begin
                        state <= desc_pkg::lane_idle;
                    end
                end
                desc_pkg::lane_fwd: begin
                    o_data_wr <= i_data_wr;
                    if (!i_data_wr || i_data[8]) begin
                        state <= desc_pkg::lane_idle;       // tail or broken frame
                    end
                end
                desc_pkg::lane_drop: begin
                    o_data_wr <= 1'b0;
                    if (!i_data_wr || i_data[8]) begin
                        state <= desc_pkg::lane_idle;
                    end
                end
                default: begin
                    o_data_wr <= 1'b0;
                    state     <= desc_pkg::lane_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // payload and descriptor fields
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        o_data <= i_data;
        if (admit_head) begin
            type_q      <= head_type;
            id_q[13:9]  <= i_data[4:0];
        end
        if (state == desc_pkg::lane_id_hi && i_data_wr && !i_data[8]) begin
            id_q[8:1] <= i_data[7:0];
        end
        if (state == desc_pkg::lane_id_lo && i_data_wr) begin
            id_q[0] <= i_data[7];
        end
    end

    assign d.port      = lane_id;
    assign d.flow_type = type_q;
    assign d.flow_id   = id_q;

endmodule

//--- logic/buf_admit.sv
// registers the per-class admit decisions from the free buffer count, shared by all lanes
`timescale 1ns/1ns

module buf_admit (
    input  logic              clk_sys,
    input  logic              reset_n,
    input  desc_pkg::bufcnt_t i_free_cnt,
    input  desc_pkg::bufcnt_t i_rc_thr,
    input  desc_pkg::bufcnt_t i_be_thr,
    output logic              o_admit_rc,
    output logic              o_admit_be,
    output logic              o_admit_other
);

    logic cnt_nonzero;
    logic above_rc;
    logic above_be;

    assign cnt_nonzero = (i_free_cnt != '0);
    assign above_rc    = (i_free_cnt > i_rc_thr);
    assign above_be    = (i_free_cnt > i_be_thr);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            o_admit_rc    <= 1'b0;
            o_admit_be    <= 1'b0;
            o_admit_other <= 1'b0;
        end else begin
            o_admit_rc    <= above_rc && cnt_nonzero;
            o_admit_be    <= above_rc && above_be && cnt_nonzero;   // be must clear both
            o_admit_other <= cnt_nonzero;
        end
    end

endmodule

//--- logic/desc_if.sv
// carries one descriptor from a port lane to the round-robin merger with valid/ready
`timescale 1ns/1ns

interface desc_if;

    logic                  valid;
    logic                  ready;
    desc_pkg::port_id_t    port;
    desc_pkg::flow_type_t  flow_type;
    desc_pkg::flow_id_t    flow_id;

    // producer side, one per port lane
    modport lane (
        output valid, port, flow_type, flow_id,
        input  ready
    );

    // consumer side in the merger
    modport arb (
        input  valid, port, flow_type, flow_id,
        output ready
    );

endinterface

//--- logic/desc_pkg.sv
// shared widths, types and constants for the descriptor extractor, referenced by scoped name
package desc_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    localparam int num_ports = 4;               // ingress lanes

    //////////////////////////////
    // data types
    //////////////////////////////

    typedef logic [8:0]  pkt_byte_t;            // bit 8 marks head and tail
    typedef logic [8:0]  bufcnt_t;              // free buffer-id count
    typedef logic [2:0]  flow_type_t;
    typedef logic [13:0] flow_id_t;
    typedef logic [3:0]  port_id_t;             // ingress port number

    // flow classes with their own admission threshold
    localparam flow_type_t flow_type_rc = 3'd3;
    localparam flow_type_t flow_type_be = 3'd6;

    //////////////////////////////
    // lane state machine
    //////////////////////////////

    // lane_id_hi waits for word 2, lane_id_lo for word 3
    typedef enum logic [2:0] {
        lane_idle,                              // waiting for a head
        lane_id_hi,                             // flow id 8..1
        lane_id_lo,                             // flow id 0
        lane_fwd,                               // forward up to the tail
        lane_drop                               // swallow a refused frame
    } lane_state_t;

endpackage
